// ==== Bender.yml ====
package:
  name: pipeline_control

sources:
  - src/pipe_ctrl_pkg.sv
  - src/ldst_if.sv
  - src/irq_vector_fetch.sv
  - src/idt_loader.sv
  - src/event_sequencer.sv
  - src/pipeline_control.sv
  - target: test
    files:
      - test/tb_pipeline_control.sv

// ==== build.f ====
src/pipe_ctrl_pkg.sv
src/ldst_if.sv
src/irq_vector_fetch.sv
src/idt_loader.sv
src/event_sequencer.sv
src/pipeline_control.sv
test/tb_pipeline_control.sv

// ==== src/event_sequencer.sv ====
`timescale 1ns/1ps
`default_nettype none

module event_sequencer (
	input wire logic iCLOCK,
	input wire logic inRESET,
	// Execute stage
	input wire logic branch_valid,
	input wire logic reload_valid,
	input wire logic idts_valid,
	input wire logic ib_valid,
	input wire logic [pipe_ctrl_pkg::XLEN-1:0] jump_addr,
	// Interrupt request
	input wire logic irq_req,
	input wire logic irq_lock,
	input wire logic [pipe_ctrl_pkg::ENTRY_W-1:0] irq_num,
	input wire logic psr_ie,
	input wire logic [pipe_ctrl_pkg::XLEN-1:0] sysreg_pcr,
	input wire logic [pipe_ctrl_pkg::XLEN-1:0] sysreg_ppcr,
	// Units
	output logic vec_start,
	output logic [pipe_ctrl_pkg::ENTRY_W-1:0] vec_irq_num,
	input wire logic vec_done,
	input wire logic [pipe_ctrl_pkg::XLEN-1:0] handler_addr,
	output logic idt_start,
	input wire logic idt_done,
	ldst_if.arbiter vec_ldst,
	ldst_if.arbiter idt_ldst,
	// Shared load/store port
	output logic ldst_use,
	output logic ldst_req,
	input wire logic ldst_busy,
	output logic [1:0] ldst_order,
	output logic ldst_rw,
	output logic [pipe_ctrl_pkg::XLEN-1:0] ldst_addr,
	output logic [pipe_ctrl_pkg::XLEN-1:0] ldst_data,
	input wire logic ldst_resp_valid,
	input wire logic [pipe_ctrl_pkg::XLEN-1:0] ldst_resp_data,
	// Pipeline events and register updates
	output logic event_hold,
	output logic event_start,
	output logic event_irq_front2back,
	output logic event_irq_back2front,
	output logic event_end,
	output logic setreg_pcr_set,
	output logic [pipe_ctrl_pkg::XLEN-1:0] setreg_pcr,
	output logic setreg_ppcr_set,
	output logic [pipe_ctrl_pkg::XLEN-1:0] setreg_ppcr,
	output logic irq_ack
);

	pipe_ctrl_pkg::ctrl_state_e state;
	pipe_ctrl_pkg::ctrl_state_e next_state;
	logic idle;
	logic irq_ok;
	logic irq_next;
	logic ret_done;
	logic fin_irq;
	logic fin_any;

	assign idle = (state == pipe_ctrl_pkg::IDLE);
	assign irq_ok = irq_req && !irq_lock && psr_ie;

	always_comb begin
		next_state = state;
		case (state)
			pipe_ctrl_pkg::IDLE: begin
				if (irq_ok && branch_valid) next_state = pipe_ctrl_pkg::JUMP_IRQ_CALL;
				else if (irq_ok) next_state = pipe_ctrl_pkg::IRQ_CALL;
				else if (branch_valid) next_state = pipe_ctrl_pkg::JUMP;
				else if (reload_valid) next_state = pipe_ctrl_pkg::RELOAD;
				else if (idts_valid) next_state = pipe_ctrl_pkg::IDT_SET;
				else if (ib_valid) next_state = pipe_ctrl_pkg::IRQ_RETURN;
			end
			default: begin
				if (fin_any) next_state = pipe_ctrl_pkg::IDLE;
			end
		endcase
	end

	assign irq_next = (next_state == pipe_ctrl_pkg::JUMP_IRQ_CALL)
		|| (next_state == pipe_ctrl_pkg::IRQ_CALL);

	// Unit start strobes on the leaving edge
	assign vec_start = idle && irq_next;
	assign vec_irq_num = irq_num;
	assign idt_start = idle && (next_state == pipe_ctrl_pkg::IDT_SET);

	// End conditions
	assign fin_irq = ((state == pipe_ctrl_pkg::JUMP_IRQ_CALL)
		|| (state == pipe_ctrl_pkg::IRQ_CALL)) && vec_done;
	assign fin_any = fin_irq || (state == pipe_ctrl_pkg::JUMP)
		|| (state == pipe_ctrl_pkg::RELOAD)
		|| ((state == pipe_ctrl_pkg::IRQ_RETURN) && ret_done)
		|| ((state == pipe_ctrl_pkg::IDT_SET) && idt_done);

	// The loader owns the port whenever it holds use
	assign vec_ldst.busy = ldst_busy || idt_ldst.use_port;
	assign idt_ldst.busy = ldst_busy;
	assign vec_ldst.resp_valid = ldst_resp_valid && vec_ldst.use_port && !idt_ldst.use_port;
	assign idt_ldst.resp_valid = ldst_resp_valid && idt_ldst.use_port;
	assign vec_ldst.resp_data = ldst_resp_data;
	assign idt_ldst.resp_data = ldst_resp_data;

	always_comb begin
		ldst_req = 1'b0;
		ldst_order = 2'h0;
		ldst_rw = 1'b0;
		ldst_addr = '0;
		ldst_data = '0;
		if (idt_ldst.use_port) begin
			ldst_req = idt_ldst.req;
			ldst_order = idt_ldst.order;
			ldst_rw = idt_ldst.rw;
			ldst_addr = idt_ldst.addr;
			ldst_data = idt_ldst.data;
		end
		else if (vec_ldst.use_port) begin
			ldst_req = vec_ldst.req;
			ldst_order = vec_ldst.order;
			ldst_rw = vec_ldst.rw;
			ldst_addr = vec_ldst.addr;
			ldst_data = vec_ldst.data;
		end
	end

	assign ldst_use = idt_ldst.use_port || vec_ldst.use_port;

	always_ff @(posedge iCLOCK or negedge inRESET) begin
		if (!inRESET) begin
			state <= pipe_ctrl_pkg::IDLE;
			ret_done <= 1'b0;
			event_hold <= 1'b0;
			event_start <= 1'b0;
			event_irq_front2back <= 1'b0;
			event_irq_back2front <= 1'b0;
			event_end <= 1'b0;
			irq_ack <= 1'b0;
			setreg_ppcr_set <= 1'b0;
			setreg_pcr_set <= 1'b0;
			setreg_pcr <= '0;
		end
		else begin
			state <= next_state;
			// Interrupt return is a fixed one-cycle wait
			ret_done <= (state == pipe_ctrl_pkg::IRQ_RETURN) && !ret_done;
			if (idle) begin
				event_hold <= (next_state != pipe_ctrl_pkg::IDLE);
			end
			event_start <= idle && (next_state != pipe_ctrl_pkg::IDLE);
			event_irq_front2back <= idle && irq_next;
			event_irq_back2front <= idle && (next_state == pipe_ctrl_pkg::IRQ_RETURN);
			event_end <= fin_any;
			irq_ack <= fin_irq;
			setreg_ppcr_set <= fin_irq;
			if (idle && ((next_state == pipe_ctrl_pkg::JUMP)
				|| (next_state == pipe_ctrl_pkg::RELOAD)
				|| (next_state == pipe_ctrl_pkg::IDT_SET))) begin
				setreg_pcr_set <= 1'b1;
				setreg_pcr <= jump_addr;
			end
			else if (idle && (next_state == pipe_ctrl_pkg::IRQ_RETURN)) begin
				setreg_pcr_set <= 1'b1;
				setreg_pcr <= sysreg_ppcr;
			end
			else if (fin_irq) begin
				setreg_pcr_set <= 1'b1;
				setreg_pcr <= handler_addr;
			end
			else if (idle) begin
				setreg_pcr_set <= 1'b0;
				setreg_pcr <= '0;
			end
		end
	end

	// PCR of the interrupted program
	always_ff @(posedge iCLOCK or negedge inRESET) begin
		if (!inRESET) begin
			setreg_ppcr <= '0;
		end
		else begin
			setreg_ppcr <= sysreg_pcr;
		end
	end

	a_single_master: assert property (@(posedge iCLOCK) disable iff (!inRESET)
		!(vec_ldst.use_port && idt_ldst.use_port));

	// Unit done pulses only while the sequencer waits for them
	a_vec_done_waited: assert property (@(posedge iCLOCK) disable iff (!inRESET)
		vec_done |-> ((state == pipe_ctrl_pkg::JUMP_IRQ_CALL)
		|| (state == pipe_ctrl_pkg::IRQ_CALL)));

	a_idt_done_waited: assert property (@(posedge iCLOCK) disable iff (!inRESET)
		idt_done |-> (state == pipe_ctrl_pkg::IDT_SET));

endmodule

`default_nettype wire

// ==== src/idt_loader.sv ====
`timescale 1ns/1ps
`default_nettype none

module idt_loader (
	input wire logic iCLOCK,
	input wire logic inRESET,
	input wire logic start,
	input wire logic [pipe_ctrl_pkg::XLEN-1:0] idtr,
	output logic done,
	output logic ict_req,
	output logic [pipe_ctrl_pkg::ENTRY_W-1:0] ict_entry,
	output logic ict_mask,
	output logic ict_valid,
	output logic [1:0] ict_level,
	ldst_if.master ldst
);

	logic [1:0] state;
	logic [pipe_ctrl_pkg::ENTRY_W-1:0] entry;
	logic [pipe_ctrl_pkg::XLEN-1:0] base;
	logic last_entry;
	logic resp_hit;
	pipe_ctrl_pkg::idt_word_u word;

	assign word = ldst.resp_data;
	assign last_entry = (entry == pipe_ctrl_pkg::IDT_ENTRIES - 1);
	assign resp_hit = (state == pipe_ctrl_pkg::UNIT_WAIT) && ldst.resp_valid;

	// Word 0 of the current descriptor
	assign ldst.use_port = (state != pipe_ctrl_pkg::UNIT_IDLE);
	assign ldst.req = (state == pipe_ctrl_pkg::UNIT_REQ) && !ldst.busy;
	assign ldst.order = pipe_ctrl_pkg::ORDER_WORD;
	assign ldst.rw = 1'b0;
	assign ldst.addr = base + entry * pipe_ctrl_pkg::IDT_STRIDE_BYTES;
	assign ldst.data = '0;

	always_ff @(posedge iCLOCK or negedge inRESET) begin
		if (!inRESET) begin
			state <= pipe_ctrl_pkg::UNIT_IDLE;
			entry <= '0;
			done <= 1'b0;
			ict_req <= 1'b0;
		end
		else begin
			done <= 1'b0;
			ict_req <= resp_hit;
			case (state)
				pipe_ctrl_pkg::UNIT_IDLE: begin
					if (start) begin
						entry <= '0;
						state <= pipe_ctrl_pkg::UNIT_REQ;
					end
				end
				pipe_ctrl_pkg::UNIT_REQ: begin
					if (!ldst.busy) begin
						state <= pipe_ctrl_pkg::UNIT_WAIT;
					end
				end
				pipe_ctrl_pkg::UNIT_WAIT: begin
					if (ldst.resp_valid) begin
						if (last_entry) begin
							// Done goes out with the last table update
							done <= 1'b1;
							state <= pipe_ctrl_pkg::UNIT_IDLE;
						end
						else begin
							entry <= entry + 1'b1;
							state <= pipe_ctrl_pkg::UNIT_REQ;
						end
					end
				end
				default: begin
					state <= pipe_ctrl_pkg::UNIT_IDLE;
				end
			endcase
		end
	end

	always_ff @(posedge iCLOCK or negedge inRESET) begin
		if (!inRESET) begin
			base <= '0;
			ict_entry <= '0;
			ict_mask <= 1'b0;
			ict_valid <= 1'b0;
			ict_level <= 2'h0;
		end
		else begin
			if (start && (state == pipe_ctrl_pkg::UNIT_IDLE)) begin
				base <= idtr;
			end
			if (resp_hit) begin
				ict_entry <= entry;
				ict_mask <= word.cfg.mask;
				ict_valid <= word.cfg.valid;
				ict_level <= word.cfg.level;
			end
		end
	end

	// Memory answers only the one outstanding read
	a_resp_while_waiting: assert property (@(posedge iCLOCK) disable iff (!inRESET)
		ldst.resp_valid |-> (state == pipe_ctrl_pkg::UNIT_WAIT));

endmodule

`default_nettype wire

// ==== src/irq_vector_fetch.sv ====
`timescale 1ns/1ps
`default_nettype none

module irq_vector_fetch (
	input wire logic iCLOCK,
	input wire logic inRESET,
	input wire logic start,
	input wire logic [pipe_ctrl_pkg::ENTRY_W-1:0] irq_num,
	input wire logic [pipe_ctrl_pkg::XLEN-1:0] idtr,
	output logic done,
	output logic [pipe_ctrl_pkg::XLEN-1:0] handler_addr,
	ldst_if.master ldst
);

	logic [1:0] state;
	logic [pipe_ctrl_pkg::XLEN-1:0] addr_q;
	pipe_ctrl_pkg::idt_word_u word;

	assign word = ldst.resp_data;

	// Read only, one word at a time
	assign ldst.use_port = (state != pipe_ctrl_pkg::UNIT_IDLE);
	assign ldst.req = (state == pipe_ctrl_pkg::UNIT_REQ) && !ldst.busy;
	assign ldst.order = pipe_ctrl_pkg::ORDER_WORD;
	assign ldst.rw = 1'b0;
	assign ldst.addr = addr_q;
	assign ldst.data = '0;

	always_ff @(posedge iCLOCK or negedge inRESET) begin
		if (!inRESET) begin
			state <= pipe_ctrl_pkg::UNIT_IDLE;
			done <= 1'b0;
		end
		else begin
			done <= 1'b0;
			case (state)
				pipe_ctrl_pkg::UNIT_IDLE: begin
					if (start) begin
						state <= pipe_ctrl_pkg::UNIT_REQ;
					end
				end
				pipe_ctrl_pkg::UNIT_REQ: begin
					if (!ldst.busy) begin
						state <= pipe_ctrl_pkg::UNIT_WAIT;
					end
				end
				pipe_ctrl_pkg::UNIT_WAIT: begin
					if (ldst.resp_valid) begin
						state <= pipe_ctrl_pkg::UNIT_IDLE;
						done <= 1'b1;
					end
				end
				default: begin
					state <= pipe_ctrl_pkg::UNIT_IDLE;
				end
			endcase
		end
	end

	always_ff @(posedge iCLOCK or negedge inRESET) begin
		if (!inRESET) begin
			addr_q <= '0;
			handler_addr <= '0;
		end
		else begin
			// Word 1 of the selected descriptor
			if (start && (state == pipe_ctrl_pkg::UNIT_IDLE)) begin
				addr_q <= idtr + irq_num * pipe_ctrl_pkg::IDT_STRIDE_BYTES
					+ pipe_ctrl_pkg::XLEN / 8;
			end
			if ((state == pipe_ctrl_pkg::UNIT_WAIT) && ldst.resp_valid) begin
				handler_addr <= word.addr;
			end
		end
	end

	// The sequencer only starts a fetch when the unit is free
	a_start_when_idle: assert property (@(posedge iCLOCK) disable iff (!inRESET)
		start |-> (state == pipe_ctrl_pkg::UNIT_IDLE));

endmodule

`default_nettype wire

// ==== src/ldst_if.sv ====
`timescale 1ns/1ps
`default_nettype none

interface ldst_if;

	// Request side, driven by the master
	logic use_port;
	logic req;
	logic [1:0] order;
	logic rw;
	logic [pipe_ctrl_pkg::XLEN-1:0] addr;
	logic [pipe_ctrl_pkg::XLEN-1:0] data;

	// Response side, driven by the arbiter
	logic busy;
	logic resp_valid;
	logic [pipe_ctrl_pkg::XLEN-1:0] resp_data;

	modport master (
		output use_port, req, order, rw, addr, data,
		input busy, resp_valid, resp_data
	);

	modport arbiter (
		input use_port, req, order, rw, addr, data,
		output busy, resp_valid, resp_data
	);

endinterface

`default_nettype wire

// ==== src/pipe_ctrl_pkg.sv ====
package pipe_ctrl_pkg;

	// Data and address width of the core
	localparam int XLEN = 32;

	// Interrupt descriptor table layout
	localparam int IDT_ENTRIES = 64;
	localparam int ENTRY_W = 6;
	// Word 0 holds the configuration, word 1 the handler address
	localparam int IDT_STRIDE_BYTES = 8;

	// Load/store order codes, 00 byte, 01 half word, 10 word
	localparam logic [1:0] ORDER_WORD = 2'h2;

	// Shared encoding of the fetching units' request FSM
	localparam logic [1:0] UNIT_IDLE = 2'h0;
	localparam logic [1:0] UNIT_REQ = 2'h1;
	localparam logic [1:0] UNIT_WAIT = 2'h2;

	// Sequencer states
	typedef enum logic [2:0] {
		IDLE = 3'h0,
		JUMP_IRQ_CALL = 3'h1,
		JUMP = 3'h2,
		IRQ_CALL = 3'h3,
		IRQ_RETURN = 3'h4,
		IDT_SET = 3'h5,
		RELOAD = 3'h6
	} ctrl_state_e;

	// Descriptor word 0
	typedef struct packed {
		logic [XLEN-5:0] reserved;
		logic [1:0] level;
		logic valid;
		logic mask;
	} idt_config_t;

	// One memory word, read as configuration or as handler address
	typedef union packed {
		idt_config_t cfg;
		logic [XLEN-1:0] addr;
	} idt_word_u;

endpackage

// ==== src/pipeline_control.sv ====
`timescale 1ns/1ps
`default_nettype none

module pipeline_control (
	input wire logic iCLOCK,
	input wire logic inRESET,
	// Core internal events
	output logic event_hold,
	output logic event_start,
	output logic event_irq_front2back,
	output logic event_irq_back2front,
	output logic event_end,
	// System register updates
	output logic setreg_pcr_set,
	output logic setreg_ppcr_set,
	output logic [pipe_ctrl_pkg::XLEN-1:0] setreg_pcr,
	output logic [pipe_ctrl_pkg::XLEN-1:0] setreg_ppcr,
	// System register inputs
	input wire logic [pipe_ctrl_pkg::XLEN-1:0] sysreg_psr,
	input wire logic [pipe_ctrl_pkg::XLEN-1:0] sysreg_pcr,
	input wire logic [pipe_ctrl_pkg::XLEN-1:0] sysreg_ppcr,
	input wire logic [pipe_ctrl_pkg::XLEN-1:0] sysreg_idtr,
	// Load/store port
	output logic ldst_use,
	output logic ldst_req,
	input wire logic ldst_busy,
	output logic [1:0] ldst_order,
	output logic ldst_rw,
	output logic [pipe_ctrl_pkg::XLEN-1:0] ldst_addr,
	output logic [pipe_ctrl_pkg::XLEN-1:0] ldst_data,
	input wire logic ldst_resp_valid,
	input wire logic [pipe_ctrl_pkg::XLEN-1:0] ldst_resp_data,
	// Interrupt configuration table
	output logic ict_req,
	output logic [pipe_ctrl_pkg::ENTRY_W-1:0] ict_entry,
	output logic ict_conf_mask,
	output logic ict_conf_valid,
	output logic [1:0] ict_conf_level,
	// Interrupt request
	input wire logic irq_req,
	input wire logic irq_lock,
	input wire logic [pipe_ctrl_pkg::ENTRY_W-1:0] irq_num,
	output logic irq_ack,
	// Execute stage
	input wire logic [pipe_ctrl_pkg::XLEN-1:0] exe_jump_addr,
	input wire logic exe_branch_valid,
	input wire logic exe_idts_valid,
	input wire logic exe_ib_valid,
	input wire logic exe_reload_valid
);

	logic vec_start;
	logic [pipe_ctrl_pkg::ENTRY_W-1:0] vec_irq_num;
	logic vec_done;
	logic [pipe_ctrl_pkg::XLEN-1:0] handler_addr;
	logic idt_start;
	logic idt_done;

	ldst_if vec_ldst ();
	ldst_if idt_ldst ();

	irq_vector_fetch vec_fetch_i (
		.iCLOCK(iCLOCK), .inRESET(inRESET),
		.start(vec_start), .irq_num(vec_irq_num), .idtr(sysreg_idtr),
		.done(vec_done), .handler_addr(handler_addr), .ldst(vec_ldst)
	);

	idt_loader idt_loader_i (
		.iCLOCK(iCLOCK), .inRESET(inRESET),
		.start(idt_start), .idtr(sysreg_idtr), .done(idt_done),
		.ict_req(ict_req), .ict_entry(ict_entry), .ict_mask(ict_conf_mask),
		.ict_valid(ict_conf_valid), .ict_level(ict_conf_level), .ldst(idt_ldst)
	);

	event_sequencer sequencer_i (
		.iCLOCK(iCLOCK), .inRESET(inRESET),
		.branch_valid(exe_branch_valid), .reload_valid(exe_reload_valid),
		.idts_valid(exe_idts_valid), .ib_valid(exe_ib_valid), .jump_addr(exe_jump_addr),
		.irq_req(irq_req), .irq_lock(irq_lock), .irq_num(irq_num),
		// Interrupt enable lives in PSR bit 2
		.psr_ie(sysreg_psr[2]),
		.sysreg_pcr(sysreg_pcr), .sysreg_ppcr(sysreg_ppcr),
		.vec_start(vec_start), .vec_irq_num(vec_irq_num),
		.vec_done(vec_done), .handler_addr(handler_addr),
		.idt_start(idt_start), .idt_done(idt_done),
		.vec_ldst(vec_ldst), .idt_ldst(idt_ldst),
		.ldst_use(ldst_use), .ldst_req(ldst_req), .ldst_busy(ldst_busy),
		.ldst_order(ldst_order), .ldst_rw(ldst_rw), .ldst_addr(ldst_addr),
		.ldst_data(ldst_data), .ldst_resp_valid(ldst_resp_valid),
		.ldst_resp_data(ldst_resp_data),
		.event_hold(event_hold), .event_start(event_start),
		.event_irq_front2back(event_irq_front2back),
		.event_irq_back2front(event_irq_back2front), .event_end(event_end),
		.setreg_pcr_set(setreg_pcr_set), .setreg_pcr(setreg_pcr),
		.setreg_ppcr_set(setreg_ppcr_set), .setreg_ppcr(setreg_ppcr),
		.irq_ack(irq_ack)
	);

endmodule

`default_nettype wire

// ==== test/tb_pipeline_control.sv ====
`timescale 1ns/1ps

module tb_pipeline_control;

	localparam int ROW_TIMEOUT = 2000;
	localparam logic [31:0] IDTR_BASE = 32'h0000_8000;
	localparam logic [1:0] DIR_NONE = 2'd0;
	localparam logic [1:0] DIR_F2B = 2'd1;
	localparam logic [1:0] DIR_B2F = 2'd2;

	typedef enum {BRANCH, RELOAD, IRQ, BRANCH_IRQ, IRQ_RET, IDT_SET} kind_e;

	typedef struct {
		kind_e kind;
		logic [31:0] jump_addr;
		logic [5:0] irq_num;
		logic lock;
		logic [31:0] psr;
		logic [31:0] pcr;
		logic [31:0] ppcr;
		logic [31:0] exp_pcr;
		logic exp_irq;
		logic [1:0] exp_dir;
	} row_t;

	logic iCLOCK;
	logic inRESET;
	logic event_hold;
	logic event_start;
	logic event_irq_front2back;
	logic event_irq_back2front;
	logic event_end;
	logic setreg_pcr_set;
	logic setreg_ppcr_set;
	logic [31:0] setreg_pcr;
	logic [31:0] setreg_ppcr;
	logic [31:0] sysreg_psr;
	logic [31:0] sysreg_pcr;
	logic [31:0] sysreg_ppcr;
	logic [31:0] sysreg_idtr;
	logic ldst_use;
	logic ldst_req;
	logic ldst_busy;
	logic [1:0] ldst_order;
	logic ldst_rw;
	logic [31:0] ldst_addr;
	logic [31:0] ldst_data;
	logic ldst_resp_valid;
	logic [31:0] ldst_resp_data;
	logic ict_req;
	logic [5:0] ict_entry;
	logic ict_conf_mask;
	logic ict_conf_valid;
	logic [1:0] ict_conf_level;
	logic irq_req;
	logic irq_lock;
	logic [5:0] irq_num;
	logic irq_ack;
	logic [31:0] exe_jump_addr;
	logic exe_branch_valid;
	logic exe_idts_valid;
	logic exe_ib_valid;
	logic exe_reload_valid;

	row_t rows[$];
	int checks = 0;
	int errors = 0;
	logic timed_out = 1'b0;
	logic [31:0] lfsr_state = 32'h4042_05cc;

	pipeline_control dut_i (.*);

	initial begin
		iCLOCK = 1'b0;
		forever #50 iCLOCK = ~iCLOCK;
	end

	// Galois LFSR, x^32 + x^22 + x^2 + x + 1
	function automatic logic [31:0] lfsr_step(input logic [31:0] s);
		if (s[0]) begin
			return (s >> 1) ^ 32'h8020_0003;
		end
		return s >> 1;
	endfunction

	function automatic logic [3:0] draw_bits(input int n);
		logic [3:0] v;
		v = '0;
		for (int i = 0; i < n; i++) begin
			lfsr_state = lfsr_step(lfsr_state);
			v = {v[2:0], lfsr_state[0]};
		end
		return v;
	endfunction

	// Descriptor contents of the memory model
	function automatic logic [31:0] config_of(input logic [5:0] e);
		return {28'h0, e[3:2], e[1], e[0]};
	endfunction

	function automatic logic [31:0] handler_of(input logic [5:0] e);
		return 32'h1000 + 32'd16 * e;
	endfunction

	function automatic logic [31:0] mem_word(input logic [31:0] addr);
		logic [31:0] offset;
		offset = addr - IDTR_BASE;
		if (offset[2]) begin
			return handler_of(offset[8:3]);
		end
		return config_of(offset[8:3]);
	endfunction

	task automatic check_value(input string name, input logic [31:0] exp,
		input logic [31:0] act);
		checks++;
		assert (act === exp) else begin
			errors++;
			$display("[ERROR] %0t %s expected %h got %h", $time, name, exp, act);
		end
	endtask

	task automatic add_row(input kind_e kind, input logic [31:0] jump, input logic [5:0] num,
		input logic lock, input logic [31:0] psr, input logic [31:0] pcr,
		input logic [31:0] ppcr, input logic [31:0] exp_pcr, input logic exp_irq,
		input logic [1:0] exp_dir);
		row_t r;
		r = '{kind, jump, num, lock, psr, pcr, ppcr, exp_pcr, exp_irq, exp_dir};
		rows.push_back(r);
	endtask

	// Load/store responder with random busy and 0 to 3 cycles of latency
	initial begin : mem_model
		logic pending;
		logic [1:0] delay;
		logic [31:0] req_addr;
		pending = 1'b0;
		delay = 2'd0;
		req_addr = '0;
		ldst_busy = 1'b0;
		ldst_resp_valid = 1'b0;
		ldst_resp_data = '0;
		forever begin
			@(negedge iCLOCK);
			if (ldst_req === 1'b1) begin
				check_value("ldst_rw", 1'b0, ldst_rw);
				check_value("ldst_order", pipe_ctrl_pkg::ORDER_WORD, ldst_order);
				check_value("ldst_busy", 1'b0, ldst_busy);
				check_value("ldst_use", 1'b1, ldst_use);
				if (pending) begin
					errors++;
					$display("Request at %0t while a response was still outstanding", $time);
				end
				if (ldst_addr - IDTR_BASE >= 32'd512) begin
					errors++;
					$display("Read at %0t outside the descriptor table, address %h",
						$time, ldst_addr);
				end
				pending = 1'b1;
				req_addr = ldst_addr;
				delay = draw_bits(2);
			end
			@(posedge iCLOCK);
			#5;
			ldst_resp_valid = 1'b0;
			ldst_busy = (draw_bits(2) == 4'h3);
			if (pending) begin
				if (delay == 2'd0) begin
					ldst_resp_valid = 1'b1;
					ldst_resp_data = mem_word(req_addr);
					pending = 1'b0;
				end
				else begin
					delay = delay - 2'd1;
				end
			end
		end
	end

	task automatic run_row(input row_t r);
		int cycle;
		int ict_count;
		int end_cycle;
		logic ended;
		logic [31:0] cfg;
		cycle = 0;
		ict_count = 0;
		ended = 1'b0;
		// Fixed lengths for sequences that do not touch memory
		end_cycle = 0;
		if (!r.exp_irq && (r.kind == BRANCH || r.kind == BRANCH_IRQ || r.kind == RELOAD)) begin
			end_cycle = 2;
		end
		else if (r.kind == IRQ_RET) begin
			end_cycle = 3;
		end
		@(posedge iCLOCK);
		#5;
		exe_branch_valid = (r.kind == BRANCH) || (r.kind == BRANCH_IRQ);
		exe_reload_valid = (r.kind == RELOAD);
		exe_idts_valid = (r.kind == IDT_SET);
		exe_ib_valid = (r.kind == IRQ_RET);
		irq_req = (r.kind == IRQ) || (r.kind == BRANCH_IRQ);
		exe_jump_addr = r.jump_addr;
		irq_num = r.irq_num;
		irq_lock = r.lock;
		sysreg_psr = r.psr;
		sysreg_pcr = r.pcr;
		sysreg_ppcr = r.ppcr;
		@(posedge iCLOCK);
		#5;
		exe_branch_valid = 1'b0;
		exe_reload_valid = 1'b0;
		exe_idts_valid = 1'b0;
		exe_ib_valid = 1'b0;
		irq_req = 1'b0;
		while (!ended && (cycle < ROW_TIMEOUT)) begin
			@(negedge iCLOCK);
			cycle++;
			check_value("event_start", cycle == 1, event_start);
			check_value("event_irq_front2back", (cycle == 1) && (r.exp_dir == DIR_F2B),
				event_irq_front2back);
			check_value("event_irq_back2front", (cycle == 1) && (r.exp_dir == DIR_B2F),
				event_irq_back2front);
			check_value("event_hold", 1'b1, event_hold);
			if (ict_req === 1'b1) begin
				cfg = config_of(ict_count[5:0]);
				check_value("ict_entry", ict_count, ict_entry);
				check_value("ict_conf_mask", cfg[0], ict_conf_mask);
				check_value("ict_conf_valid", cfg[1], ict_conf_valid);
				check_value("ict_conf_level", cfg[3:2], ict_conf_level);
				ict_count++;
			end
			ended = (event_end === 1'b1);
			check_value("irq_ack", ended && r.exp_irq, irq_ack);
			check_value("setreg_ppcr_set", ended && r.exp_irq, setreg_ppcr_set);
			check_value("setreg_pcr_set", ended || !r.exp_irq, setreg_pcr_set);
			if (ended || !r.exp_irq) begin
				check_value("setreg_pcr", r.exp_pcr, setreg_pcr);
			end
			if (ended && r.exp_irq) begin
				check_value("setreg_ppcr", r.pcr, setreg_ppcr);
			end
			if (ended && (end_cycle != 0)) begin
				check_value("event_end cycle", end_cycle, cycle);
			end
		end
		if (!ended) begin
			errors++;
			timed_out = 1'b1;
			$display("Row %s: event_end did not arrive within %0d cycles",
				r.kind.name(), ROW_TIMEOUT);
			return;
		end
		check_value("ict_req count", (r.kind == IDT_SET) ? 64 : 0, ict_count);
		// First idle cycle after the sequence
		@(negedge iCLOCK);
		check_value("event_hold", 1'b0, event_hold);
		check_value("event_end", 1'b0, event_end);
		check_value("setreg_pcr_set", 1'b0, setreg_pcr_set);
		check_value("irq_ack", 1'b0, irq_ack);
		check_value("ldst_use", 1'b0, ldst_use);
		// Released port drives zeros
		check_value("ldst_addr", 32'h0, ldst_addr);
		check_value("ldst_data", 32'h0, ldst_data);
	endtask

	initial begin
		int err_before;
		inRESET = 1'b0;
		sysreg_psr = '0;
		sysreg_pcr = '0;
		sysreg_ppcr = '0;
		sysreg_idtr = IDTR_BASE;
		irq_req = 1'b0;
		irq_lock = 1'b0;
		irq_num = '0;
		exe_jump_addr = '0;
		exe_branch_valid = 1'b0;
		exe_idts_valid = 1'b0;
		exe_ib_valid = 1'b0;
		exe_reload_valid = 1'b0;

		// kind, jump, irq_num, lock, psr, pcr, ppcr, expected pcr, irq, direction
		add_row(BRANCH, 32'h2000, 6'd0, 1'b0, 32'h4, 32'h100, 32'h0, 32'h2000, 1'b0, DIR_NONE);
		add_row(RELOAD, 32'h3404, 6'd0, 1'b0, 32'h4, 32'h104, 32'h0, 32'h3404, 1'b0, DIR_NONE);
		add_row(IRQ, 32'h0, 6'd5, 1'b0, 32'h4, 32'h204, 32'h0, handler_of(6'd5), 1'b1, DIR_F2B);
		add_row(BRANCH_IRQ, 32'h4000, 6'd7, 1'b1, 32'h4, 32'h300, 32'h0, 32'h4000, 1'b0,
			DIR_NONE);
		add_row(BRANCH_IRQ, 32'h4100, 6'd9, 1'b0, 32'hfb, 32'h304, 32'h0, 32'h4100, 1'b0,
			DIR_NONE);
		add_row(BRANCH_IRQ, 32'h4200, 6'd63, 1'b0, 32'h4, 32'h308, 32'h0, handler_of(6'd63),
			1'b1, DIR_F2B);
		add_row(IRQ_RET, 32'h0, 6'd0, 1'b0, 32'h4, 32'h400, 32'h5a5c, 32'h5a5c, 1'b0, DIR_B2F);
		add_row(IDT_SET, 32'h6000, 6'd0, 1'b0, 32'h4, 32'h404, 32'h0, 32'h6000, 1'b0,
			DIR_NONE);
		add_row(IRQ, 32'h0, 6'd0, 1'b0, 32'h4, 32'h40c, 32'h0, handler_of(6'd0), 1'b1, DIR_F2B);
		add_row(RELOAD, 32'h7008, 6'd0, 1'b0, 32'h0, 32'h500, 32'h0, 32'h7008, 1'b0, DIR_NONE);

		repeat (2) @(posedge iCLOCK);
		#5;
		inRESET = 1'b1;
		@(negedge iCLOCK);
		check_value("event_hold", 1'b0, event_hold);
		check_value("event_start", 1'b0, event_start);
		check_value("event_irq_front2back", 1'b0, event_irq_front2back);
		check_value("event_irq_back2front", 1'b0, event_irq_back2front);
		check_value("event_end", 1'b0, event_end);
		check_value("setreg_pcr_set", 1'b0, setreg_pcr_set);
		check_value("setreg_ppcr_set", 1'b0, setreg_ppcr_set);
		check_value("irq_ack", 1'b0, irq_ack);
		check_value("ldst_use", 1'b0, ldst_use);
		check_value("ldst_req", 1'b0, ldst_req);
		check_value("ict_req", 1'b0, ict_req);

		for (int i = 0; (i < rows.size()) && !timed_out; i++) begin
			err_before = errors;
			run_row(rows[i]);
			$display("Row %0d %s: %s", i, rows[i].kind.name(),
				(errors == err_before) ? "ok" : "FAILED");
		end
		$display("Rows %0d, checks %0d, errors %0d", rows.size(), checks, errors);
		if (errors == 0) begin
			$display("Done: no errors");
		end
		else begin
			$display("Done: errors found");
		end
		$finish;
	end

endmodule
